// ==== verilog/cache_pkg.sv ====
// geometry and control map are fixed here; changing a width means rechecking every block
`default_nettype none

package cache_pkg;

   // word addressing, no byte offset in addresses
   localparam int ADDR_W        = 12;
   localparam int DATA_W        = 32;
   localparam int NBYTES        = 4;

   // 16 lines of 4 words
   localparam int NLINES_W      = 4;
   localparam int WORD_OFFSET_W = 2;
   localparam int TAG_W         = ADDR_W - NLINES_W - WORD_OFFSET_W;

   // write-through buffer holds 4 entries
   localparam int WTBUF_DEPTH_W = 2;

   // control space register index
   localparam int CTRL_ADDR_W   = 3;

   // counters, read-only, order matches the event vector in control
   localparam logic [CTRL_ADDR_W-1:0] REG_READ_HIT   = 3'd0;
   localparam logic [CTRL_ADDR_W-1:0] REG_READ_MISS  = 3'd1;
   localparam logic [CTRL_ADDR_W-1:0] REG_WRITE_HIT  = 3'd2;
   localparam logic [CTRL_ADDR_W-1:0] REG_WRITE_MISS = 3'd3;
   // bit 0 buffer empty, bit 1 buffer full
   localparam logic [CTRL_ADDR_W-1:0] REG_STATUS     = 3'd4;
   // write-only commands
   localparam logic [CTRL_ADDR_W-1:0] REG_INVALIDATE = 3'd5;
   localparam logic [CTRL_ADDR_W-1:0] REG_CNT_CLEAR  = 3'd6;

endpackage

`default_nettype wire

// ==== verilog/cache_front_end.sv ====
// req must stay high with stable fields until ack; only one request is held at a time
`timescale 1ns/10ps
`default_nettype none

module cache_front_end (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               req,
   input  logic [cache_pkg::ADDR_W:0]         addr,
   input  logic [cache_pkg::DATA_W-1:0]       wdata,
   input  logic [cache_pkg::NBYTES-1:0]       wstrb,
   output logic [cache_pkg::DATA_W-1:0]       rdata,
   output logic                               ack,
   output logic                               data_req,
   output logic [cache_pkg::ADDR_W-1:0]       data_addr_reg,
   output logic [cache_pkg::DATA_W-1:0]       data_wdata_reg,
   output logic [cache_pkg::NBYTES-1:0]       data_wstrb_reg,
   input  logic [cache_pkg::DATA_W-1:0]       data_rdata,
   input  logic                               data_ack,
   output logic                               ctrl_req,
   output logic [cache_pkg::CTRL_ADDR_W-1:0]  ctrl_addr,
   output logic                               ctrl_write,
   input  logic [cache_pkg::DATA_W-1:0]       ctrl_rdata,
   input  logic                               ctrl_ack
);
   import cache_pkg::*;

   logic busy;
   logic ctrl_space;
   logic capture;

   // sample only while idle
   assign capture = req && !busy;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy       <= 1'b0;
         ctrl_space <= 1'b0;
      end else if (capture) begin
         busy       <= 1'b1;
         ctrl_space <= addr[ADDR_W];
      end else if (ack) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         data_addr_reg  <= addr[ADDR_W-1:0];
         data_wdata_reg <= wdata;
         data_wstrb_reg <= wstrb;
      end
   end

   assign data_req = busy && !ctrl_space;
   assign ctrl_req = busy && ctrl_space;

   // control shares the held address and strobes
   assign ctrl_addr  = data_addr_reg[CTRL_ADDR_W-1:0];
   assign ctrl_write = |data_wstrb_reg;

   assign ack   = data_ack | ctrl_ack;
   assign rdata = ctrl_space ? ctrl_rdata : data_rdata;

   a_one_space: assert property (@(posedge clk) disable iff (!arst_n)
      !(data_req && ctrl_req));

   // neither block may answer a request that was never raised
   a_ack_busy: assert property (@(posedge clk) disable iff (!arst_n)
      ack |-> busy);

endmodule

`default_nettype wire

// ==== verilog/cache_memory.sv ====
// direct-mapped, write-through, no write allocate; refill waits on the back end draining first
`timescale 1ns/10ps
`default_nettype none

module cache_memory (
   input  logic                                                 clk,
   input  logic                                                 arst_n,
   input  logic                                                 data_req,
   input  logic [cache_pkg::ADDR_W-1:0]                         data_addr_reg,
   input  logic [cache_pkg::DATA_W-1:0]                         data_wdata_reg,
   input  logic [cache_pkg::NBYTES-1:0]                         data_wstrb_reg,
   output logic [cache_pkg::DATA_W-1:0]                         data_rdata,
   output logic                                                 data_ack,
   output logic                                                 wtb_push,
   output logic [cache_pkg::ADDR_W-1:0]                         wtb_addr,
   output logic [cache_pkg::DATA_W-1:0]                         wtb_wdata,
   output logic [cache_pkg::NBYTES-1:0]                         wtb_wstrb,
   input  logic                                                 wtb_full,
   output logic                                                 refill_req,
   output logic [cache_pkg::ADDR_W-cache_pkg::WORD_OFFSET_W-1:0] refill_addr,
   input  logic                                                 refill_word_valid,
   input  logic [cache_pkg::WORD_OFFSET_W-1:0]                  refill_word_idx,
   input  logic [cache_pkg::DATA_W-1:0]                         refill_rdata,
   input  logic                                                 invalidate,
   output logic                                                 read_hit,
   output logic                                                 read_miss,
   output logic                                                 write_hit,
   output logic                                                 write_miss
);
   import cache_pkg::*;

   logic [TAG_W-1:0]         tag_mem [2**NLINES_W];
   logic [DATA_W-1:0]        data_mem [2**(NLINES_W+WORD_OFFSET_W)];
   logic [2**NLINES_W-1:0]   valid;

   logic                     refilling;
   logic                     ack_q;
   logic [DATA_W-1:0]        rdata_q;

   logic [TAG_W-1:0]         tag;
   logic [NLINES_W-1:0]      index;
   logic [WORD_OFFSET_W-1:0] offset;
   logic                     is_write;
   logic                     hit;
   logic                     lookup;
   logic                     refill_last;

   assign tag      = data_addr_reg[ADDR_W-1 -: TAG_W];
   assign index    = data_addr_reg[WORD_OFFSET_W +: NLINES_W];
   assign offset   = data_addr_reg[WORD_OFFSET_W-1:0];
   assign is_write = |data_wstrb_reg;
   assign hit      = valid[index] && (tag_mem[index] == tag);

   // request still high in its ack cycle, so ack_q blocks a second lookup
   assign lookup = data_req && !ack_q && !refilling;

   assign read_hit   = lookup && !is_write && hit;
   assign read_miss  = lookup && !is_write && !hit;
   // writes stall here until the buffer has a free slot
   assign write_hit  = lookup && is_write && !wtb_full && hit;
   assign write_miss = lookup && is_write && !wtb_full && !hit;

   assign refill_last = refilling && refill_word_valid && (refill_word_idx == '1);
   assign refill_req  = refilling;
   assign refill_addr = data_addr_reg[ADDR_W-1:WORD_OFFSET_W];

   // held request fields stay stable through the ack cycle
   assign wtb_push  = ack_q && is_write;
   assign wtb_addr  = data_addr_reg;
   assign wtb_wdata = data_wdata_reg;
   assign wtb_wstrb = data_wstrb_reg;

   assign data_ack   = ack_q;
   assign data_rdata = rdata_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         refilling <= 1'b0;
         ack_q     <= 1'b0;
         valid     <= '0;
      end else begin
         ack_q <= read_hit || write_hit || write_miss || refill_last;
         if (read_miss) begin
            refilling    <= 1'b1;
            // line is overwritten word by word
            valid[index] <= 1'b0;
         end
         if (refill_last) begin
            refilling    <= 1'b0;
            valid[index] <= 1'b1;
         end
         if (invalidate) begin
            valid <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (refilling && refill_word_valid) begin
         data_mem[{index, refill_word_idx}] <= refill_rdata;
         tag_mem[index] <= tag;
         // keep the requested word as it passes
         if (refill_word_idx == offset) begin
            rdata_q <= refill_rdata;
         end
      end
      if (read_hit) begin
         rdata_q <= data_mem[{index, offset}];
      end
      if (write_hit) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (data_wstrb_reg[b]) begin
               data_mem[{index, offset}][8*b +: 8] <= data_wdata_reg[8*b +: 8];
            end
         end
      end
   end

   // full was checked a cycle before the push
   a_push_not_full: assert property (@(posedge clk) disable iff (!arst_n)
      wtb_push |-> !wtb_full);

endmodule

`default_nettype wire

// ==== verilog/cache_write_buffer.sv ====
// 4-entry write FIFO; a push while full is not guarded here, the producer must check wtb_full
`timescale 1ns/10ps
`default_nettype none

module cache_write_buffer (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          wtb_push,
   input  logic [cache_pkg::ADDR_W-1:0]  wtb_addr,
   input  logic [cache_pkg::DATA_W-1:0]  wtb_wdata,
   input  logic [cache_pkg::NBYTES-1:0]  wtb_wstrb,
   output logic                          wtb_valid,
   output logic [cache_pkg::ADDR_W-1:0]  wtb_head_addr,
   output logic [cache_pkg::DATA_W-1:0]  wtb_head_wdata,
   output logic [cache_pkg::NBYTES-1:0]  wtb_head_wstrb,
   input  logic                          wtb_pop,
   output logic                          wtb_full,
   output logic                          wtb_empty
);
   import cache_pkg::*;

   // one entry is {addr, wstrb, wdata}
   logic [ADDR_W+NBYTES+DATA_W-1:0] fifo_mem [2**WTBUF_DEPTH_W];
   // extra msb tells full from empty
   logic [WTBUF_DEPTH_W:0]          wr_ptr;
   logic [WTBUF_DEPTH_W:0]          rd_ptr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wtb_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (wtb_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wtb_push) begin
         fifo_mem[wr_ptr[WTBUF_DEPTH_W-1:0]] <= {wtb_addr, wtb_wstrb, wtb_wdata};
      end
   end

   assign wtb_empty = (wr_ptr == rd_ptr);
   assign wtb_full  = (wr_ptr[WTBUF_DEPTH_W] != rd_ptr[WTBUF_DEPTH_W])
                   && (wr_ptr[WTBUF_DEPTH_W-1:0] == rd_ptr[WTBUF_DEPTH_W-1:0]);
   assign wtb_valid = !wtb_empty;

   assign {wtb_head_addr, wtb_head_wstrb, wtb_head_wdata} = fifo_mem[rd_ptr[WTBUF_DEPTH_W-1:0]];

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
      wtb_pop |-> !wtb_empty);

endmodule

`default_nettype wire

// ==== verilog/cache_back_end.sv ====
// drains have priority; a refill starts only with the buffer empty so it never reads stale words
`timescale 1ns/10ps
`default_nettype none

module cache_back_end (
   input  logic                                                 clk,
   input  logic                                                 arst_n,
   input  logic                                                 wtb_valid,
   input  logic [cache_pkg::ADDR_W-1:0]                         wtb_head_addr,
   input  logic [cache_pkg::DATA_W-1:0]                         wtb_head_wdata,
   input  logic [cache_pkg::NBYTES-1:0]                         wtb_head_wstrb,
   output logic                                                 wtb_pop,
   input  logic                                                 wtb_empty,
   input  logic                                                 refill_req,
   input  logic [cache_pkg::ADDR_W-cache_pkg::WORD_OFFSET_W-1:0] refill_addr,
   output logic                                                 refill_word_valid,
   output logic [cache_pkg::WORD_OFFSET_W-1:0]                  refill_word_idx,
   output logic [cache_pkg::DATA_W-1:0]                         refill_rdata,
   output logic                                                 mem_req,
   output logic                                                 mem_we,
   output logic [cache_pkg::ADDR_W-1:0]                         mem_addr,
   output logic [cache_pkg::DATA_W-1:0]                         mem_wdata,
   output logic [cache_pkg::NBYTES-1:0]                         mem_wstrb,
   input  logic [cache_pkg::DATA_W-1:0]                         mem_rdata,
   input  logic                                                 mem_ack
);
   import cache_pkg::*;

   typedef enum logic [1:0] {BE_IDLE, BE_WRITE, BE_REFILL} be_state_t;

   be_state_t                state;
   logic [WORD_OFFSET_W-1:0] word_cnt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= BE_IDLE;
         word_cnt <= '0;
      end else begin
         case (state)
            BE_IDLE: begin
               if (wtb_valid) begin
                  state <= BE_WRITE;
               end else if (refill_req && wtb_empty) begin
                  state    <= BE_REFILL;
                  word_cnt <= '0;
               end
            end
            BE_WRITE: begin
               if (mem_ack) begin
                  state <= BE_IDLE;
               end
            end
            BE_REFILL: begin
               // one read per word, counter wraps back to 0 at the end
               if (mem_ack) begin
                  word_cnt <= word_cnt + 1'b1;
                  if (word_cnt == '1) begin
                     state <= BE_IDLE;
                  end
               end
            end
            default: state <= BE_IDLE;
         endcase
      end
   end

   // buffer head is stable until the pop
   assign mem_req   = (state != BE_IDLE);
   assign mem_we    = (state == BE_WRITE);
   assign mem_addr  = mem_we ? wtb_head_addr : {refill_addr, word_cnt};
   assign mem_wdata = wtb_head_wdata;
   assign mem_wstrb = mem_we ? wtb_head_wstrb : '0;

   assign wtb_pop = mem_we && mem_ack;

   assign refill_word_valid = (state == BE_REFILL) && mem_ack;
   assign refill_word_idx   = word_cnt;
   assign refill_rdata      = mem_rdata;

   a_mem_stable: assert property (@(posedge clk) disable iff (!arst_n)
      mem_req && !mem_ack |=> mem_req && $stable(mem_we) && $stable(mem_addr)
                              && $stable(mem_wdata) && $stable(mem_wstrb));

endmodule

`default_nettype wire

// ==== verilog/cache_control.sv ====
// counters saturate at all ones; reads of the write-only registers return zero
`timescale 1ns/10ps
`default_nettype none

module cache_control (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               ctrl_req,
   input  logic [cache_pkg::CTRL_ADDR_W-1:0]  ctrl_addr,
   input  logic                               ctrl_write,
   output logic [cache_pkg::DATA_W-1:0]       ctrl_rdata,
   output logic                               ctrl_ack,
   input  logic                               read_hit,
   input  logic                               read_miss,
   input  logic                               write_hit,
   input  logic                               write_miss,
   input  logic                               wtb_full,
   input  logic                               wtb_empty,
   output logic                               invalidate
);
   import cache_pkg::*;

   logic [DATA_W-1:0] cnt [4];
   logic [3:0]        events;
   logic              access;
   logic              cnt_clear;

   // index order follows REG_READ_HIT .. REG_WRITE_MISS
   assign events    = {write_miss, write_hit, read_miss, read_hit};
   assign access    = ctrl_req && !ctrl_ack;
   assign cnt_clear = access && ctrl_write && (ctrl_addr == REG_CNT_CLEAR);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ctrl_ack   <= 1'b0;
         invalidate <= 1'b0;
         for (int i = 0; i < 4; i++) begin
            cnt[i] <= '0;
         end
      end else begin
         ctrl_ack   <= access;
         invalidate <= access && ctrl_write && (ctrl_addr == REG_INVALIDATE);
         for (int i = 0; i < 4; i++) begin
            if (cnt_clear) begin
               cnt[i] <= '0;
            end else if (events[i] && (cnt[i] != '1)) begin
               cnt[i] <= cnt[i] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         case (ctrl_addr)
            REG_READ_HIT, REG_READ_MISS, REG_WRITE_HIT, REG_WRITE_MISS:
               ctrl_rdata <= cnt[ctrl_addr[1:0]];
            REG_STATUS:
               ctrl_rdata <= {{(DATA_W-2){1'b0}}, wtb_full, wtb_empty};
            default:
               ctrl_rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/cache_top.sv ====
// one front-end request in flight; addr[ADDR_W] selects control space, which is always present
`timescale 1ns/10ps
`default_nettype none

module cache_top (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          req,
   input  logic [cache_pkg::ADDR_W:0]    addr,
   input  logic [cache_pkg::DATA_W-1:0]  wdata,
   input  logic [cache_pkg::NBYTES-1:0]  wstrb,
   output logic [cache_pkg::DATA_W-1:0]  rdata,
   output logic                          ack,
   input  logic                          invalidate_in,
   output logic                          invalidate_out,
   input  logic                          wtb_empty_in,
   output logic                          wtb_empty_out,
   output logic                          mem_req,
   output logic                          mem_we,
   output logic [cache_pkg::ADDR_W-1:0]  mem_addr,
   output logic [cache_pkg::DATA_W-1:0]  mem_wdata,
   output logic [cache_pkg::NBYTES-1:0]  mem_wstrb,
   input  logic [cache_pkg::DATA_W-1:0]  mem_rdata,
   input  logic                          mem_ack
);
   import cache_pkg::*;

   // front end to cache memory
   logic                            data_req;
   logic [ADDR_W-1:0]               data_addr_reg;
   logic [DATA_W-1:0]               data_wdata_reg;
   logic [NBYTES-1:0]               data_wstrb_reg;
   logic [DATA_W-1:0]               data_rdata;
   logic                            data_ack;

   // front end to control
   logic                            ctrl_req;
   logic [CTRL_ADDR_W-1:0]          ctrl_addr;
   logic                            ctrl_write;
   logic [DATA_W-1:0]               ctrl_rdata;
   logic                            ctrl_ack;
   logic                            ctrl_invalidate;

   // write buffer, both sides
   logic                            wtb_push;
   logic [ADDR_W-1:0]               wtb_addr;
   logic [DATA_W-1:0]               wtb_wdata;
   logic [NBYTES-1:0]               wtb_wstrb;
   logic                            wtb_valid;
   logic [ADDR_W-1:0]               wtb_head_addr;
   logic [DATA_W-1:0]               wtb_head_wdata;
   logic [NBYTES-1:0]               wtb_head_wstrb;
   logic                            wtb_pop;
   logic                            wtb_full;
   logic                            wtb_empty;

   // line refill
   logic                            refill_req;
   logic [ADDR_W-WORD_OFFSET_W-1:0] refill_addr;
   logic                            refill_word_valid;
   logic [WORD_OFFSET_W-1:0]        refill_word_idx;
   logic [DATA_W-1:0]               refill_rdata;

   // hit and miss events
   logic                            read_hit;
   logic                            read_miss;
   logic                            write_hit;
   logic                            write_miss;

   // chain gates for multi-cache systems
   assign invalidate_out = ctrl_invalidate | invalidate_in;
   assign wtb_empty_out  = wtb_empty & wtb_empty_in;

   cache_front_end i_front_end (.*);

   cache_memory i_cache_memory (.*, .invalidate(invalidate_out));

   cache_write_buffer i_write_buffer (.*);

   cache_back_end i_back_end (.*);

   cache_control i_control (.*, .invalidate(ctrl_invalidate));

endmodule

`default_nettype wire

// ==== verif/tb_memory_model.sv ====
// word-addressed backing memory, random fill from a fixed seed; hold_ack freezes every transfer
`timescale 1ns/10ps
`default_nettype none

module tb_memory_model (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          hold_ack,
   input  logic                          mem_req,
   input  logic                          mem_we,
   input  logic [cache_pkg::ADDR_W-1:0]  mem_addr,
   input  logic [cache_pkg::DATA_W-1:0]  mem_wdata,
   input  logic [cache_pkg::NBYTES-1:0]  mem_wstrb,
   output logic [cache_pkg::DATA_W-1:0]  mem_rdata,
   output logic                          mem_ack
);
   import cache_pkg::*;

   logic [DATA_W-1:0] mem [2**ADDR_W];
   logic [1:0]        delay;
   integer            seed;

   initial begin
      seed = 32'h47ae;
      for (int i = 0; i < 2**ADDR_W; i++) begin
         mem[i] <= $random(seed);
      end
   end

   // one transfer per ack, then a fresh random wait of 0 to 3 cycles
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_ack   <= 1'b0;
         mem_rdata <= '0;
         delay     <= '0;
      end else if (mem_ack) begin
         mem_ack <= 1'b0;
      end else if (mem_req && !hold_ack) begin
         if (delay == 2'd0) begin
            mem_ack   <= 1'b1;
            mem_rdata <= mem[mem_addr];
            if (mem_we) begin
               for (int b = 0; b < NBYTES; b++) begin
                  if (mem_wstrb[b]) begin
                     mem[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
                  end
               end
            end
            delay <= 2'($random(seed));
         end else begin
            delay <= delay - 2'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verif/tb_cache.sv ====
// single master, one request at a time; expected values come from a shadow memory and line table
`timescale 1ns/10ps
`default_nettype none

module tb_cache;
   import cache_pkg::*;

   localparam int ACK_LIMIT = 400;
   // req sampled one edge after the drive, ack two cycles later
   localparam int FAST_ACK = 3;

   logic clk = 1'b0;
   logic arst_n = 1'b0;
   logic req = 1'b0;
   logic [ADDR_W:0] addr = '0;
   logic [DATA_W-1:0] wdata = '0;
   logic [NBYTES-1:0] wstrb = '0;
   logic [DATA_W-1:0] rdata;
   logic ack;
   logic invalidate_in = 1'b0;
   logic invalidate_out;
   logic wtb_empty_in = 1'b1;
   logic wtb_empty_out;
   logic hold_ack = 1'b0;
   logic mem_req;
   logic mem_we;
   logic mem_ack;
   logic [ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_wdata;
   logic [DATA_W-1:0] mem_rdata;
   logic [NBYTES-1:0] mem_wstrb;

   logic [DATA_W-1:0] shadow [2**ADDR_W];
   logic              line_valid [2**NLINES_W];
   logic [TAG_W-1:0]  line_tag [2**NLINES_W];
   int                n_rd_hit;
   int                n_rd_miss;
   int                n_wr_hit;
   int                n_wr_miss;
   integer            seed;

   always #20 clk = ~clk;

   cache_top i_dut (.*);

   tb_memory_model i_mem (.*);

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
      assert (got === exp)
      else fail_run($sformatf("mismatch at %0t ns: %s, got %h, expected %h",
                              $time, what, got, exp));
   endtask

   a_inv_chain: assert property (@(posedge clk) disable iff (!arst_n)
      invalidate_in |-> invalidate_out)
   else fail_run("invalidate_out did not follow invalidate_in");

   a_empty_chain: assert property (@(posedge clk) disable iff (!arst_n)
      !wtb_empty_in |-> !wtb_empty_out)
   else fail_run("wtb_empty_out was high while wtb_empty_in was low");

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
         input logic [DATA_W-1:0] wd, input logic [NBYTES-1:0] ws);
      logic [DATA_W-1:0] res;
      res = old;
      for (int b = 0; b < NBYTES; b++) begin
         if (ws[b]) begin
            res[8*b +: 8] = wd[8*b +: 8];
         end
      end
      return res;
   endfunction

   task automatic start_req(input logic space, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] wd, input logic [NBYTES-1:0] ws);
      @(posedge clk);
      req   <= 1'b1;
      addr  <= {space, a};
      wdata <= wd;
      wstrb <= ws;
   endtask

   // counts falling edges until ack, then drops req
   task automatic wait_ack(output logic [DATA_W-1:0] rd, output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > ACK_LIMIT) begin
            fail_run("no ack from the cache before the timeout");
         end
      end while (!ack);
      rd = rdata;
      @(posedge clk);
      req <= 1'b0;
   endtask

   task automatic read_check(input logic [ADDR_W-1:0] a);
      logic [DATA_W-1:0] rd;
      int                cycles;
      logic [NLINES_W-1:0] idx;
      logic              hit;
      idx = a[WORD_OFFSET_W +: NLINES_W];
      hit = line_valid[idx] && (line_tag[idx] == a[ADDR_W-1 -: TAG_W]);
      start_req(1'b0, a, '0, '0);
      wait_ack(rd, cycles);
      check_value(rd, shadow[a], $sformatf("read of %h", a));
      if (hit) begin
         n_rd_hit++;
         check_value(cycles, FAST_ACK, "read hit ack latency");
      end else begin
         n_rd_miss++;
         line_valid[idx] = 1'b1;
         line_tag[idx]   = a[ADDR_W-1 -: TAG_W];
      end
   endtask

   task automatic write_count(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] wd,
                              input logic [NBYTES-1:0] ws);
      logic [NLINES_W-1:0] idx;
      idx = a[WORD_OFFSET_W +: NLINES_W];
      if (line_valid[idx] && (line_tag[idx] == a[ADDR_W-1 -: TAG_W])) begin
         n_wr_hit++;
      end else begin
         n_wr_miss++;
      end
      shadow[a] = merge_bytes(shadow[a], wd, ws);
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] wd,
                             input logic [NBYTES-1:0] ws);
      logic [DATA_W-1:0] rd;
      int                cycles;
      write_count(a, wd, ws);
      start_req(1'b0, a, wd, ws);
      wait_ack(rd, cycles);
   endtask

   task automatic ctrl_access(input logic [CTRL_ADDR_W-1:0] r, input logic wr,
                              output logic [DATA_W-1:0] rd);
      int cycles;
      start_req(1'b1, ADDR_W'(r), '0, wr ? 4'hf : 4'h0);
      wait_ack(rd, cycles);
      check_value(cycles, FAST_ACK, "control ack latency");
   endtask

   task automatic counters_check();
      logic [DATA_W-1:0] rd;
      ctrl_access(REG_READ_HIT, 1'b0, rd);
      check_value(rd, n_rd_hit, "read hit counter");
      ctrl_access(REG_READ_MISS, 1'b0, rd);
      check_value(rd, n_rd_miss, "read miss counter");
      ctrl_access(REG_WRITE_HIT, 1'b0, rd);
      check_value(rd, n_wr_hit, "write hit counter");
      ctrl_access(REG_WRITE_MISS, 1'b0, rd);
      check_value(rd, n_wr_miss, "write miss counter");
   endtask

   task automatic drain_check();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > ACK_LIMIT) begin
            fail_run("write buffer did not drain before the timeout");
         end
      end while (!wtb_empty_out);
      for (int i = 0; i < 2**ADDR_W; i++) begin
         check_value(i_mem.mem[i], shadow[i], $sformatf("memory word %h", i));
      end
   endtask

   initial begin
      logic [DATA_W-1:0] rd;
      logic [ADDR_W-1:0] a;
      logic [NBYTES-1:0] ws;
      int                cycles;
      seed = 32'h47ae;
      // same draw order as the memory model fill
      for (int i = 0; i < 2**ADDR_W; i++) begin
         shadow[i] = $random(seed);
      end
      for (int i = 0; i < 2**NLINES_W; i++) begin
         line_valid[i] = 1'b0;
         line_tag[i]   = '0;
      end
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      // whole lines first, then scattered reads with tag conflicts
      for (int i = 0; i < 64; i++) begin
         read_check(ADDR_W'(i));
      end
      for (int i = 0; i < 80; i++) begin
         read_check(ADDR_W'($random(seed)) & 12'h1ff);
      end

      wtb_empty_in <= 1'b0;
      for (int i = 0; i < 40; i++) begin
         a  = ADDR_W'($random(seed)) & 12'h1ff;
         ws = NBYTES'($random(seed));
         if (ws == '0) begin
            ws = 4'b0001;
         end
         write_word(a, $random(seed), ws);
         read_check(a);
      end
      wtb_empty_in <= 1'b1;
      drain_check();

      counters_check();
      ctrl_access(REG_CNT_CLEAR, 1'b1, rd);
      n_rd_hit  = 0;
      n_rd_miss = 0;
      n_wr_hit  = 0;
      n_wr_miss = 0;
      counters_check();

      // both invalidate sources drop every line
      ctrl_access(REG_INVALIDATE, 1'b1, rd);
      for (int i = 0; i < 2**NLINES_W; i++) begin
         line_valid[i] = 1'b0;
      end
      for (int i = 0; i < 64; i += 4) begin
         read_check(ADDR_W'(i));
      end
      @(posedge clk);
      invalidate_in <= 1'b1;
      @(posedge clk);
      invalidate_in <= 1'b0;
      for (int i = 0; i < 2**NLINES_W; i++) begin
         line_valid[i] = 1'b0;
      end
      for (int i = 0; i < 64; i += 4) begin
         read_check(ADDR_W'(i));
      end
      counters_check();

      // stalled memory lets four writes fill the buffer
      hold_ack <= 1'b1;
      for (int i = 0; i < 4; i++) begin
         write_word(12'h300 + ADDR_W'(i), $random(seed), 4'hf);
      end
      ctrl_access(REG_STATUS, 1'b0, rd);
      check_value(rd, 32'h2, "status with the buffer full");
      a = 12'h304;
      write_count(a, 32'hcafe_f00d, 4'b0110);
      start_req(1'b0, a, 32'hcafe_f00d, 4'b0110);
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         assert (!ack) else fail_run("write was acknowledged while the buffer was full");
         assert (!wtb_empty_out)
         else fail_run("wtb_empty_out was high while writes were still buffered");
      end
      @(posedge clk);
      hold_ack <= 1'b0;
      wait_ack(rd, cycles);
      read_check(a);
      drain_check();
      ctrl_access(REG_STATUS, 1'b0, rd);
      check_value(rd, 32'h1, "status with the buffer empty");
      counters_check();

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/cache_pkg.sv
verilog/cache_front_end.sv
verilog/cache_memory.sv
verilog/cache_write_buffer.sv
verilog/cache_back_end.sv
verilog/cache_control.sv
verilog/cache_top.sv
verif/tb_memory_model.sv
verif/tb_cache.sv

// ==== run.sh ====
#!/bin/sh
# builds the cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_cache -f build.f -o sim_cache
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/sim_cache
status=$?
if [ $status -ne 0 ]; then
   echo "simulation ended with status $status"
   exit $status
fi

exit 0
